// File: Makefile
TOP = debugLinkTb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f filelist.f --top-module debugLinkTop

sim:
	verilator --binary --timing --assert -j 0 -f filelist.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "Test completed successfully" > /dev/null

clean:
	rm -rf obj_dir

// File: common/debugLinkPkg.sv
package debugLinkPkg;

    // ======================================================================
    // Widths with a meaning on the link
    // ======================================================================

    // One byte on the serial line
    typedef logic [7:0] byteT;

    // Register file, 16 words of 16 bits
    typedef logic [3:0] regAddrT;
    typedef logic [15:0] regDataT;

    // LED register
    typedef logic [3:0] ledT;

    // Type byte plus length byte
    localparam int headerLen = 2;

    // ======================================================================
    // Message type codes
    // ======================================================================

    // Zero on the type position is idle and never forms a message
    localparam byteT msgSetLed = 8'd1;
    localparam byteT msgWriteReg = 8'd2;
    localparam byteT msgReadReg = 8'd3;
    localparam byteT msgEcho = 8'd4;

endpackage

// File: filelist.f
common/debugLinkPkg.sv
source/msgQueue.sv
serialRx/serialRx.sv
msgHandler/msgHandler.sv
serialTx/msgFramer.sv
serialTx/serialTx.sv
source/debugLinkTop.sv
verification/debugLinkChecker.sv
verification/debugLinkTb.sv

// File: msgHandler/msgHandler.sv
`timescale 1ns/1ps

module msgHandler #(
    parameter int maxPayloadLen = 3
) (
    input  logic clk,
    input  logic reset,
    input  logic inValid,
    input  logic [(debugLinkPkg::headerLen + maxPayloadLen) * 8 - 1:0] inMsg,
    output logic inPop,
    output debugLinkPkg::ledT led,
    output logic respReq,
    input  logic respAck,
    output debugLinkPkg::byteT respType,
    output debugLinkPkg::byteT respLen,
    output logic [maxPayloadLen * 8 - 1:0] respPayload
);
    localparam int payW = maxPayloadLen * 8;
    localparam int msgW = payW + debugLinkPkg::headerLen * 8;
    localparam debugLinkPkg::byteT maxLenByte = debugLinkPkg::byteT'(maxPayloadLen);

    typedef enum logic [1:0] {
        idle,
        decode,
        request,
        releasing
    } stateT;

    stateT state;
    logic [msgW-1:0] msgReg;
    debugLinkPkg::byteT msgType;
    debugLinkPkg::byteT msgLen;
    logic [payW-1:0] msgPayload;
    debugLinkPkg::regAddrT regAddr;
    debugLinkPkg::regDataT regFile [16];
    debugLinkPkg::regDataT readData;

    // Fields of the popped message
    assign msgType = msgReg[7:0];
    assign msgLen = msgReg[15:8];
    assign msgPayload = msgReg[msgW-1:16];
    assign regAddr = msgPayload[3:0];
    assign readData = regFile[regAddr];

    // ======================================================================
    // Message execution and request side of the handshake
    // ======================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
            inPop <= 1'b0;
            respReq <= 1'b0;
            led <= '0;
            for (int i = 0; i < 16; i++) begin
                regFile[i] <= '0;
            end
        end else begin
            case (state)
                idle: begin
                    if (inPop && inValid) begin
                        inPop <= 1'b0;
                        state <= decode;
                    end else begin
                        inPop <= inValid;
                    end
                end
                decode: begin
                    state <= idle;
                    case (msgType)
                        debugLinkPkg::msgSetLed: begin
                            led <= msgPayload[3:0];
                        end
                        debugLinkPkg::msgWriteReg: begin
                            // Data arrives high byte first
                            regFile[regAddr] <= {msgPayload[15:8], msgPayload[23:16]};
                        end
                        debugLinkPkg::msgReadReg, debugLinkPkg::msgEcho: begin
                            respReq <= 1'b1;
                            state <= request;
                        end
                        default: begin
                            // Unknown types are consumed silently
                        end
                    endcase
                end
                request: begin
                    if (respAck) begin
                        respReq <= 1'b0;
                        state <= releasing;
                    end
                end
                default: begin
                    // Framer drops its ack before the next request
                    if (!respAck) begin
                        state <= idle;
                    end
                end
            endcase
        end
    end

    // Message capture and reply payload
    always_ff @(posedge clk) begin
        if (state == idle && inPop && inValid) begin
            msgReg <= inMsg;
        end
        if (state == decode) begin
            respType <= msgType;
            if (msgType == debugLinkPkg::msgReadReg) begin
                respLen <= 8'd3;
                respPayload <= payW'({readData[7:0], readData[15:8], 4'd0, regAddr});
            end else begin
                respLen <= (msgLen > maxLenByte) ? maxLenByte : msgLen;
                respPayload <= msgPayload;
            end
        end
    end

    // Request stays up until the framer has taken the whole reply
    reqHeldUntilAck: assert property (@(posedge clk) disable iff (reset)
        respReq && !respAck |=> respReq)
        else $error("msgHandler: respReq dropped before respAck");

endmodule

// File: serialRx/serialRx.sv
`timescale 1ns/1ps

module serialRx #(
    parameter int maxPayloadLen = 3
) (
    input  logic clk,
    input  logic reset,
    input  logic debugCs,
    input  logic debugDi,
    output logic inPush,
    output logic [(debugLinkPkg::headerLen + maxPayloadLen) * 8 - 1:0] inMsg,
    input  logic inFull
);
    localparam int msgW = (debugLinkPkg::headerLen + maxPayloadLen) * 8;

    typedef enum logic [1:0] {
        waitType,
        waitLen,
        payload
    } stateT;

    stateT state;
    logic [8:0] shiftReg;
    logic byteReady;
    debugLinkPkg::byteT rxByte;
    debugLinkPkg::byteT payloadCount;
    logic [msgW-1:0] msgBuf;

    // ======================================================================
    // Bit shifter
    // ======================================================================

    // Sentinel starts at bit 0 and reaches bit 8 with the eighth data bit
    assign byteReady = shiftReg[8];
    assign rxByte = shiftReg[7:0];

    always_ff @(posedge clk) begin
        if (reset || !debugCs) begin
            shiftReg <= 9'd1;
        end else if (byteReady) begin
            // Restart with sentinel and the first bit of the next byte
            shiftReg <= {7'd0, 1'b1, debugDi};
        end else begin
            shiftReg <= {shiftReg[7:0], debugDi};
        end
    end

    // ======================================================================
    // Message framing
    // ======================================================================

    // Message being built doubles as the queue entry
    assign inMsg = msgBuf;

    always_ff @(posedge clk) begin
        if (reset || !debugCs) begin
            state <= waitType;
            inPush <= 1'b0;
            payloadCount <= '0;
        end else begin
            inPush <= 1'b0;
            if (byteReady) begin
                case (state)
                    waitType: begin
                        // Zero type bytes are idle fill
                        if (rxByte != '0) begin
                            state <= waitLen;
                        end
                    end
                    waitLen: begin
                        payloadCount <= '0;
                        if (rxByte == '0) begin
                            inPush <= !inFull;
                            state <= waitType;
                        end else begin
                            state <= payload;
                        end
                    end
                    default: begin
                        payloadCount <= payloadCount + 8'd1;
                        if (payloadCount + 8'd1 == msgBuf[15:8]) begin
                            // Whole message dropped if the queue has no room
                            inPush <= !inFull;
                            state <= waitType;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (debugCs && byteReady) begin
            if (state == waitType && rxByte != '0) begin
                // Unused payload positions stay zero
                msgBuf <= msgW'(rxByte);
            end else if (state == waitLen) begin
                msgBuf[15:8] <= rxByte;
            end else if (state == payload) begin
                for (int i = 0; i < maxPayloadLen; i++) begin
                    if (payloadCount == 8'(i)) begin
                        msgBuf[(i + debugLinkPkg::headerLen) * 8 +: 8] <= rxByte;
                    end
                end
            end
        end
    end

endmodule

// File: serialTx/msgFramer.sv
`timescale 1ns/1ps

module msgFramer #(
    parameter int maxPayloadLen = 3
) (
    input  logic clk,
    input  logic reset,
    input  logic respReq,
    output logic respAck,
    input  debugLinkPkg::byteT respType,
    input  debugLinkPkg::byteT respLen,
    input  logic [maxPayloadLen * 8 - 1:0] respPayload,
    output logic outPush,
    output debugLinkPkg::byteT outByte,
    input  logic outFull
);
    typedef enum logic [1:0] {
        idle,
        send,
        ackWait
    } stateT;

    stateT state;
    logic [8:0] byteIdx;
    logic [8:0] lastIdx;

    // Header bytes come first, then the payload
    assign lastIdx = {1'b0, respLen} + 9'(debugLinkPkg::headerLen - 1);

    always_comb begin
        outByte = '0;
        if (byteIdx == 9'd0) begin
            outByte = respType;
        end else if (byteIdx == 9'd1) begin
            outByte = respLen;
        end else begin
            for (int i = 0; i < maxPayloadLen; i++) begin
                if (byteIdx == 9'(i + debugLinkPkg::headerLen)) begin
                    outByte = respPayload[i * 8 +: 8];
                end
            end
        end
    end

    // One byte per cycle while the queue has room
    assign outPush = (state == send) && !outFull;

    // ======================================================================
    // Acknowledge side of the handshake
    // ======================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
            respAck <= 1'b0;
            byteIdx <= '0;
        end else begin
            case (state)
                idle: begin
                    if (respReq) begin
                        byteIdx <= '0;
                        state <= send;
                    end
                end
                send: begin
                    if (!outFull) begin
                        if (byteIdx == lastIdx) begin
                            respAck <= 1'b1;
                            state <= ackWait;
                        end else begin
                            byteIdx <= byteIdx + 9'd1;
                        end
                    end
                end
                default: begin
                    if (!respReq) begin
                        respAck <= 1'b0;
                        state <= idle;
                    end
                end
            endcase
        end
    end

endmodule

// File: serialTx/serialTx.sv
`timescale 1ns/1ps

module serialTx (
    input  logic clk,
    input  logic reset,
    input  logic debugCs,
    input  logic outValid,
    input  debugLinkPkg::byteT outByte,
    output logic outPop,
    output logic debugDo
);
    logic [8:0] shiftReg;
    logic loadByte;
    debugLinkPkg::byteT nextByte;

    // ======================================================================
    // Byte loading
    // ======================================================================

    // Empty register means the first slot after select rises
    // Sentinel at bit 7 means the last bit of the byte is on the line
    assign loadByte = debugCs && (shiftReg == 9'd0 || shiftReg[7:0] == 8'h80);

    // Zero byte when nothing is queued
    assign nextByte = outValid ? outByte : 8'h00;
    assign outPop = loadByte && outValid;

    // ======================================================================
    // Shifter
    // ======================================================================

    always_ff @(posedge clk) begin
        if (reset || !debugCs) begin
            shiftReg <= '0;
        end else if (loadByte) begin
            // Sentinel trails the data
            shiftReg <= {nextByte, 1'b1};
        end else begin
            shiftReg <= {shiftReg[7:0], 1'b0};
        end
    end

    // MSB first
    assign debugDo = shiftReg[8];

endmodule

// File: source/debugLinkTop.sv
`timescale 1ns/1ps

module debugLinkTop #(
    parameter int maxPayloadLen = 3,
    parameter int inDepth = 4,
    parameter int outDepth = 16
) (
    input  logic clk,
    input  logic reset,
    input  logic debugCs,
    input  logic debugDi,
    output logic debugDo,
    output debugLinkPkg::ledT led
);
    localparam int msgW = (debugLinkPkg::headerLen + maxPayloadLen) * 8;
    localparam int payW = maxPayloadLen * 8;

    // Inbound side
    logic inPush;
    logic [msgW-1:0] inMsg;
    logic inFull;
    logic inValid;
    logic inPop;
    logic [msgW-1:0] inMsgOut;

    // Reply handshake
    logic respReq;
    logic respAck;
    debugLinkPkg::byteT respType;
    debugLinkPkg::byteT respLen;
    logic [payW-1:0] respPayload;

    // Outbound side
    logic outPush;
    debugLinkPkg::byteT outByte;
    logic outFull;
    logic outValid;
    logic outPop;
    debugLinkPkg::byteT outHead;

    // ======================================================================
    // Input side
    // ======================================================================

    serialRx #(
        .maxPayloadLen(maxPayloadLen)
    ) rx (
        .clk(clk),
        .reset(reset),
        .debugCs(debugCs),
        .debugDi(debugDi),
        .inPush(inPush),
        .inMsg(inMsg),
        .inFull(inFull)
    );

    msgQueue #(
        .width(msgW),
        .depth(inDepth)
    ) inQueue (
        .clk(clk),
        .reset(reset),
        .push(inPush),
        .pushData(inMsg),
        .full(inFull),
        .pop(inPop),
        .popData(inMsgOut),
        .valid(inValid)
    );

    // ======================================================================
    // Processing
    // ======================================================================

    msgHandler #(
        .maxPayloadLen(maxPayloadLen)
    ) handler (
        .clk(clk),
        .reset(reset),
        .inValid(inValid),
        .inMsg(inMsgOut),
        .inPop(inPop),
        .led(led),
        .respReq(respReq),
        .respAck(respAck),
        .respType(respType),
        .respLen(respLen),
        .respPayload(respPayload)
    );

    // ======================================================================
    // Output side
    // ======================================================================

    msgFramer #(
        .maxPayloadLen(maxPayloadLen)
    ) framer (
        .clk(clk),
        .reset(reset),
        .respReq(respReq),
        .respAck(respAck),
        .respType(respType),
        .respLen(respLen),
        .respPayload(respPayload),
        .outPush(outPush),
        .outByte(outByte),
        .outFull(outFull)
    );

    msgQueue #(
        .width(8),
        .depth(outDepth)
    ) outQueue (
        .clk(clk),
        .reset(reset),
        .push(outPush),
        .pushData(outByte),
        .full(outFull),
        .pop(outPop),
        .popData(outHead),
        .valid(outValid)
    );

    serialTx tx (
        .clk(clk),
        .reset(reset),
        .debugCs(debugCs),
        .outValid(outValid),
        .outByte(outHead),
        .outPop(outPop),
        .debugDo(debugDo)
    );

endmodule

// File: source/msgQueue.sv
`timescale 1ns/1ps

module msgQueue #(
    parameter int width = 8,
    parameter int depth = 4
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             push,
    input  logic [width-1:0] pushData,
    output logic             full,
    input  logic             pop,
    output logic [width-1:0] popData,
    output logic             valid
);
    localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntW = $clog2(depth + 1);

    logic [width-1:0] mem [depth];
    logic [ptrW-1:0] rdPtr;
    logic [ptrW-1:0] wrPtr;
    logic [cntW-1:0] count;
    logic doPush;
    logic doPop;

    assign full = (count == cntW'(depth));
    assign valid = (count != '0);
    assign doPush = push && !full;
    assign doPop = pop && valid;

    // Head entry is always visible
    assign popData = mem[rdPtr];

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            case ({doPush, doPop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Producer and consumer must both look at the flags first
    noPushWhenFull: assert property (@(posedge clk) disable iff (reset) push |-> !full)
        else $error("msgQueue: push while full");
    noPopWhenEmpty: assert property (@(posedge clk) disable iff (reset) pop |-> valid)
        else $error("msgQueue: pop while empty");

endmodule

// File: verification/debugLinkChecker.sv
`timescale 1ns/1ps

module debugLinkChecker (
    input logic clk,
    input logic reset,
    input logic debugCs,
    input logic debugDo,
    input debugLinkPkg::ledT led
);
    typedef enum logic [1:0] {
        frameType,
        frameLen,
        framePayload
    } frameStateT;

    frameStateT frameState = frameType;
    logic csSeen = 1'b0;
    int bitCount = 0;
    int bytesLeft = 0;
    int errorCount = 0;
    debugLinkPkg::byteT shiftIn = '0;
    // Expected reply bytes in line order
    debugLinkPkg::byteT expQ [$];

    task automatic expectByte(input debugLinkPkg::byteT b);
        expQ.push_back(b);
    endtask

    function automatic int pendingBytes();
        return expQ.size();
    endfunction

    task automatic checkLed(input debugLinkPkg::ledT expLed);
        if (led !== expLed) begin
            $display("mismatch at %0t: led is 0x%0h, expected 0x%0h", $time, led, expLed);
            errorCount++;
        end
    endtask

    task automatic finishTest(input debugLinkPkg::ledT expLed);
        if (expQ.size() != 0) begin
            $display("error at %0t: %0d expected reply bytes never arrived",
                $time, expQ.size());
            errorCount++;
            expQ.delete();
        end
        checkLed(expLed);
    endtask

    task automatic compareByte(input debugLinkPkg::byteT b, input string field);
        debugLinkPkg::byteT expB;
        if (expQ.size() == 0) begin
            $display("mismatch at %0t: unexpected reply %s byte 0x%02h", $time, field, b);
            errorCount++;
        end else begin
            expB = expQ.pop_front();
            if (b !== expB) begin
                $display("mismatch at %0t: reply %s byte 0x%02h, expected 0x%02h",
                    $time, field, b, expB);
                errorCount++;
            end
        end
    endtask

    // ======================================================================
    // Frame decoder
    // ======================================================================

    task automatic frameByte(input debugLinkPkg::byteT b);
        case (frameState)
            frameType: begin
                // Zero bytes between frames are idle fill
                if (b != 8'h00) begin
                    compareByte(b, "type");
                    frameState = frameLen;
                end
            end
            frameLen: begin
                compareByte(b, "length");
                bytesLeft = int'(b);
                frameState = (b == 8'h00) ? frameType : framePayload;
            end
            default: begin
                compareByte(b, "payload");
                bytesLeft--;
                if (bytesLeft == 0) begin
                    frameState = frameType;
                end
            end
        endcase
    endtask

    always @(posedge clk) begin
        csSeen <= debugCs && !reset;
    end

    // Bit k sits on debugDo from edge k+1 on and is read in the middle of the cycle
    always @(negedge clk) begin
        if (!csSeen) begin
            if (frameState != frameType) begin
                $display("error at %0t: reply frame cut off by a low chip select", $time);
                errorCount++;
            end
            bitCount = 0;
            frameState = frameType;
        end else begin
            shiftIn = {shiftIn[6:0], debugDo};
            bitCount++;
            if (bitCount == 8) begin
                bitCount = 0;
                frameByte(shiftIn);
            end
        end
    end

endmodule

// File: verification/debugLinkTb.sv
`timescale 1ns/1ps

module debugLinkTb;
    localparam int clkPeriod = 4;
    localparam int numTests = 5;
    localparam int msgsPerTest = 12;
    localparam int maxPayload = 3;
    // Longest message plus idle bytes around it
    localparam int maxMsgBytes = 16;
    localparam int flushBytes = 8;
    localparam int quietBytes = 2;
    localparam int totalBytes =
        numTests * (msgsPerTest * maxMsgBytes + flushBytes + quietBytes) + 16;
    localparam int watchdogNs = totalBytes * 8 * clkPeriod + 2000;

    logic clk;
    logic reset;
    logic debugCs;
    logic debugDi;
    logic debugDo;
    debugLinkPkg::ledT led;

    integer seed;
    debugLinkPkg::regDataT modelReg [16];
    debugLinkPkg::ledT modelLed;
    int testsRun;
    int lastErrors;

    debugLinkTop dut (
        .clk(clk),
        .reset(reset),
        .debugCs(debugCs),
        .debugDi(debugDi),
        .debugDo(debugDo),
        .led(led)
    );

    debugLinkChecker chk (
        .clk(clk),
        .reset(reset),
        .debugCs(debugCs),
        .debugDo(debugDo),
        .led(led)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    function automatic int randomRange(input int lo, input int hi);
        int unsigned r;
        r = $random(seed);
        return lo + int'(r % (hi - lo + 1));
    endfunction

    function automatic debugLinkPkg::byteT randomByte();
        return debugLinkPkg::byteT'(randomRange(0, 255));
    endfunction

    // ======================================================================
    // Serial line driving with one bit per cycle and MSB first
    // ======================================================================

    task automatic shiftByte(input debugLinkPkg::byteT b);
        for (int i = 7; i >= 0; i--) begin
            debugDi = b[i];
            @(posedge clk);
            #1;
        end
    endtask

    task automatic idleBytes(input int n);
        repeat (n) shiftByte(8'h00);
    endtask

    task automatic selectOn();
        debugCs = 1'b1;
    endtask

    task automatic selectOff();
        debugCs = 1'b0;
        debugDi = 1'b0;
        repeat (3) @(posedge clk);
        #1;
    endtask

    // ======================================================================
    // Messages and their model
    // ======================================================================

    task automatic writeReg(input debugLinkPkg::byteT addr, input debugLinkPkg::regDataT data);
        shiftByte(debugLinkPkg::msgWriteReg);
        shiftByte(8'd3);
        shiftByte(addr);
        shiftByte(data[15:8]);
        shiftByte(data[7:0]);
        modelReg[addr[3:0]] = data;
    endtask

    task automatic readReg(input debugLinkPkg::byteT addr);
        debugLinkPkg::regDataT data;
        data = modelReg[addr[3:0]];
        chk.expectByte(debugLinkPkg::msgReadReg);
        chk.expectByte(8'd3);
        chk.expectByte({4'd0, addr[3:0]});
        chk.expectByte(data[15:8]);
        chk.expectByte(data[7:0]);
        shiftByte(debugLinkPkg::msgReadReg);
        shiftByte(8'd1);
        shiftByte(addr);
        idleBytes(6);
    endtask

    task automatic setLed(input debugLinkPkg::byteT value);
        shiftByte(debugLinkPkg::msgSetLed);
        shiftByte(8'd1);
        shiftByte(value);
        modelLed = value[3:0];
    endtask

    task automatic echoPayload(input int len);
        debugLinkPkg::byteT data [5];
        int keep;
        keep = (len > maxPayload) ? maxPayload : len;
        for (int i = 0; i < 5; i++) begin
            data[i] = randomByte();
        end
        chk.expectByte(debugLinkPkg::msgEcho);
        chk.expectByte(8'(keep));
        for (int i = 0; i < keep; i++) begin
            chk.expectByte(data[i]);
        end
        shiftByte(debugLinkPkg::msgEcho);
        shiftByte(8'(len));
        for (int i = 0; i < len; i++) begin
            shiftByte(data[i]);
        end
        idleBytes(6);
    endtask

    task automatic unknownMsg();
        int len;
        len = randomRange(0, 3);
        shiftByte(debugLinkPkg::byteT'(randomRange(5, 255)));
        shiftByte(8'(len));
        repeat (len) shiftByte(randomByte());
    endtask

    task automatic closeTest(input int num, input string name);
        int errs;
        int waited;
        waited = 0;
        // Line stays busy until every expected reply byte has been decoded
        while (chk.pendingBytes() != 0 && waited < flushBytes) begin
            shiftByte(8'h00);
            waited++;
        end
        idleBytes(quietBytes);
        chk.finishTest(modelLed);
        selectOff();
        errs = chk.errorCount - lastErrors;
        lastErrors = chk.errorCount;
        testsRun++;
        if (errs == 0) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            $display("test %0d %s: %0d errors", num, name, errs);
        end
    endtask

    // ======================================================================
    // Test sequence
    // ======================================================================

    initial begin
        debugLinkPkg::byteT addr;
        debugLinkPkg::regDataT data;
        seed = 53006;
        reset = 1'b1;
        debugCs = 1'b0;
        debugDi = 1'b0;
        modelLed = '0;
        testsRun = 0;
        lastErrors = 0;
        for (int i = 0; i < 16; i++) begin
            modelReg[i] = '0;
        end
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);
        #1;

        selectOn();
        for (int i = 0; i < msgsPerTest / 2; i++) begin
            addr = randomByte();
            writeReg(addr, debugLinkPkg::regDataT'(randomRange(0, 65535)));
            readReg(addr);
            readReg(randomByte());
        end
        closeTest(1, "register write and read");

        selectOn();
        for (int i = 0; i < msgsPerTest; i++) begin
            setLed(randomByte());
            idleBytes(1);
            chk.checkLed(modelLed);
        end
        closeTest(2, "led register");

        selectOn();
        for (int i = 0; i < msgsPerTest; i++) begin
            echoPayload(randomRange(0, 5));
        end
        closeTest(3, "echo");

        selectOn();
        for (int i = 0; i < msgsPerTest; i++) begin
            idleBytes(randomRange(0, 3));
            case (randomRange(0, 2))
                0: unknownMsg();
                1: echoPayload(randomRange(0, 3));
                default: readReg(randomByte());
            endcase
        end
        closeTest(4, "idle bytes and unknown types");

        selectOn();
        for (int i = 0; i < 4; i++) begin
            addr = randomByte();
            data = debugLinkPkg::regDataT'(randomRange(0, 65535));
            writeReg(addr, data);
            // Write cut off after its address byte must leave the register alone
            shiftByte(debugLinkPkg::msgWriteReg);
            shiftByte(8'd3);
            shiftByte(addr);
            selectOff();
            selectOn();
            readReg(addr);
        end
        closeTest(5, "chip select drop");

        $display("tests run: %0d, errors: %0d", testsRun, chk.errorCount);
        if (chk.errorCount == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(watchdogNs);
        $display("watchdog timeout: the stimulus did not finish in time");
        $display("Test failed");
        $finish;
    end

endmodule
